// File: hw/axi_lite_cfg_slave.sv
`timescale 1ns/1ps

module axi_lite_cfg_slave (
  input  logic                   Clk_CI,
  input  logic                   Rst_RBI,
  input  rab_cfg_pkg::axi_addr_t s_axi_awaddr_i,
  input  logic                   s_axi_awvalid_i,
  output logic                   s_axi_awready_o,
  input  rab_cfg_pkg::axi_data_t s_axi_wdata_i,
  input  rab_cfg_pkg::axi_strb_t s_axi_wstrb_i,
  input  logic                   s_axi_wvalid_i,
  output logic                   s_axi_wready_o,
  output logic [1:0]             s_axi_bresp_o,
  output logic                   s_axi_bvalid_o,
  input  logic                   s_axi_bready_i,
  input  rab_cfg_pkg::axi_addr_t s_axi_araddr_i,
  input  logic                   s_axi_arvalid_i,
  output logic                   s_axi_arready_o,
  output rab_cfg_pkg::axi_data_t s_axi_rdata_o,
  output logic [1:0]             s_axi_rresp_o,
  output logic                   s_axi_rvalid_o,
  input  logic                   s_axi_rready_i,
  cfg_bus_if.slave               bus
);
  import rab_cfg_pkg::*;

  wr_state_e wr_state_q, wr_state_d;
  rd_state_e rd_state_q;
  logic      wr_en_q;
  axi_addr_t awaddr_q;
  axi_data_t wdata_q;
  axi_strb_t wstrb_q;
  axi_addr_t araddr_q;
  axi_data_t rdata_q;
  logic      aw_hs, w_hs, b_hs, ar_hs, r_hs;

  // Ready and valid come straight from the FSM states
  assign s_axi_awready_o = (wr_state_q == WR_IDLE) || (wr_state_q == WR_DATA);
  assign s_axi_wready_o  = (wr_state_q == WR_IDLE) || (wr_state_q == WR_ADDR);
  assign s_axi_bvalid_o  = (wr_state_q == WR_RESP);
  assign s_axi_bresp_o   = AXI_RESP_OKAY;
  assign s_axi_arready_o = (rd_state_q == RD_IDLE);
  assign s_axi_rvalid_o  = (rd_state_q == RD_RESP);
  assign s_axi_rresp_o   = AXI_RESP_OKAY;
  assign s_axi_rdata_o   = rdata_q;

  assign aw_hs = s_axi_awvalid_i && s_axi_awready_o;
  assign w_hs  = s_axi_wvalid_i && s_axi_wready_o;
  assign b_hs  = s_axi_bvalid_o && s_axi_bready_i;
  assign ar_hs = s_axi_arvalid_i && s_axi_arready_o;
  assign r_hs  = s_axi_rvalid_o && s_axi_rready_i;

  always_comb
  begin
    wr_state_d = wr_state_q;
    unique case (wr_state_q)
      WR_IDLE:
      begin
        if (aw_hs && w_hs)
          wr_state_d = WR_RESP;
        else if (aw_hs)
          wr_state_d = WR_ADDR;
        else if (w_hs)
          wr_state_d = WR_DATA;
      end
      WR_ADDR: if (w_hs) wr_state_d = WR_RESP;
      WR_DATA: if (aw_hs) wr_state_d = WR_RESP;
      WR_RESP: if (b_hs) wr_state_d = WR_IDLE;
      default: wr_state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_state_q <= WR_IDLE;
      wr_en_q    <= 1'b0;
      rd_state_q <= RD_IDLE;
    end
    else
    begin
      wr_state_q <= wr_state_d;
      wr_en_q    <= (wr_state_d == WR_RESP) && (wr_state_q != WR_RESP); // Once per write
      if (ar_hs)
        rd_state_q <= RD_RESP;
      else if (r_hs)
        rd_state_q <= RD_IDLE;
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (aw_hs)
      awaddr_q <= s_axi_awaddr_i;
    if (w_hs)
    begin
      wdata_q <= s_axi_wdata_i;
      wstrb_q <= s_axi_wstrb_i;
    end
    if (ar_hs)
    begin
      araddr_q <= s_axi_araddr_i;
      rdata_q  <= bus.mh_hit ? bus.mh_rdata : bus.l1_rdata; // Frozen until R handshake
    end
  end

  assign bus.wr_en   = wr_en_q;
  assign bus.wr_addr = awaddr_q;
  assign bus.wr_data = wdata_q;
  assign bus.wr_strb = wstrb_q;

  // While idle the targets decode the incoming address so data can be sampled on AR
  assign bus.rd_addr = (rd_state_q == RD_IDLE) ? s_axi_araddr_i : araddr_q;

  // A FIFO that filled up after AR no longer matches the returned empty word
  assign bus.rd_pop = r_hs && (bus.mh_rdata == rdata_q);

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o)
    else $error("bvalid dropped before bready");

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o))
    else $error("rvalid or rdata changed before rready");

endmodule

// File: hw/cfg_bus_if.sv
`timescale 1ns/1ps

interface cfg_bus_if;
  import rab_cfg_pkg::*;

  // Write request, held stable while wr_en pulses
  logic      wr_en;
  axi_addr_t wr_addr;
  axi_data_t wr_data;
  axi_strb_t wr_strb;

  // Read request
  axi_addr_t rd_addr;
  logic      rd_pop;   // R handshake

  // Read return paths
  axi_data_t l1_rdata;
  logic      mh_hit;   // Address belongs to a miss FIFO
  axi_data_t mh_rdata;

  modport slave (
    output wr_en, wr_addr, wr_data, wr_strb, rd_addr, rd_pop,
    input  l1_rdata, mh_hit, mh_rdata
  );

  modport l1 (
    input  wr_en, wr_addr, wr_data, wr_strb, rd_addr,
    output l1_rdata
  );

  modport mh (
    input  wr_en, wr_addr, wr_data, wr_strb, rd_addr, rd_pop,
    output mh_hit, mh_rdata
  );

endinterface

// File: hw/l1_cfg_regs.sv
`timescale 1ns/1ps

module l1_cfg_regs (
  input  logic                                               Clk_CI,
  input  logic                                               Rst_RBI,
  cfg_bus_if.l1                                              bus,
  output rab_cfg_pkg::axi_data_t [rab_cfg_pkg::N_REGS-1:0]   l1_cfg_o
);
  import rab_cfg_pkg::*;

  axi_data_t regs_q [N_REGS];
  reg_idx_t  wr_idx;
  reg_idx_t  rd_idx;
  logic      wr_hit;
  axi_data_t strb_mask;
  axi_data_t rd_reg;

  // Valid bits of a register, by kind in the low two index bits
  function automatic axi_data_t kind_mask(reg_idx_t idx);
    axi_data_t mask;
    if (!idx[1])
      mask = axi_data_t'({ADDR_WIDTH_VIRT{1'b1}});   // Virtual start or end
    else if (!idx[0])
      mask = axi_data_t'({ADDR_WIDTH_PHYS{1'b1}});   // Physical address
    else
      mask = axi_data_t'({N_FLAGS{1'b1}});           // Flags
    return mask;
  endfunction

  assign wr_idx = bus.wr_addr[ADDR_MSB:ADDR_LSB];
  assign wr_hit = bus.wr_en && (bus.wr_addr < axi_addr_t'(CFG_SPACE_SIZE));

  // Expand byte strobes to a bit mask
  always_comb
  begin
    for (int b = 0; b < AXI_STRB_WIDTH; b++)
    begin
      strb_mask[b*8 +: 8] = {8{bus.wr_strb[b]}};
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      regs_q <= '{default: '0};
    end
    else if (wr_hit)
    begin
      // Bits outside the kind's width are cleared on every write
      regs_q[wr_idx] <= ((regs_q[wr_idx] & ~strb_mask) | (bus.wr_data & strb_mask))
                        & kind_mask(wr_idx);
    end
  end

  always_comb
  begin
    for (int r = 0; r < N_REGS; r++)
    begin
      l1_cfg_o[r] = regs_q[r] & kind_mask(reg_idx_t'(r));
    end
  end

  assign rd_idx = bus.rd_addr[ADDR_MSB:ADDR_LSB];
  assign rd_reg = l1_cfg_o[rd_idx];

  // Bit 2 selects the upper word for 32-bit masters
  assign bus.l1_rdata = bus.rd_addr[ADDR_LSB-1]
                      ? axi_data_t'(rd_reg[AXI_DATA_WIDTH-1:AXI_DATA_WIDTH/2])
                      : rd_reg;

endmodule

// File: hw/mh_fifo.sv
`timescale 1ns/1ps

module mh_fifo #(
  parameter int unsigned DATA_WIDTH = 32,
  parameter int unsigned DEPTH      = 8
) (
  input  logic                  Clk_CI,
  input  logic                  Rst_RBI,
  input  logic                  push_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic                  pop_i,
  output logic [DATA_WIDTH-1:0] data_o,
  output logic                  empty_o,
  output logic                  full_o
);

  logic [DATA_WIDTH-1:0]      mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;

  assign empty_o = (count_q == '0);
  assign full_o  = (int'(count_q) == DEPTH);
  assign data_o  = empty_o ? '0 : mem_q[rd_ptr_q]; // Head, zero when empty

  always_ff @(posedge Clk_CI)
  begin
    if (push_i)
      mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= (int'(wr_ptr_q) == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= (int'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      // Simultaneous push and pop keep the count
      if (push_i && !pop_i)
        count_q <= count_q + 1'b1;
      else if (pop_i && !push_i)
        count_q <= count_q - 1'b1;
    end
  end

  // Callers must gate push and pop with the flags
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) push_i |-> !full_o)
    else $error("push into full FIFO");

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) pop_i |-> !empty_o)
    else $error("pop from empty FIFO");

endmodule

// File: hw/miss_handler.sv
`timescale 1ns/1ps

module miss_handler (
  input  logic                    Clk_CI,
  input  logic                    Rst_RBI,
  cfg_bus_if.mh                   bus,
  input  rab_cfg_pkg::virt_addr_t miss_addr_i,
  input  rab_cfg_pkg::miss_meta_t miss_meta_i,
  input  logic                    miss_i,
  output logic                    mh_fifo_full_o
);
  import rab_cfg_pkg::*;

  logic       addr_wr_hit, meta_wr_hit;
  logic       addr_rd_hit, meta_rd_hit;
  logic       addr_push, meta_push;
  logic       addr_pop, meta_pop;
  virt_addr_t addr_din, addr_dout;
  miss_meta_t meta_din, meta_dout;
  logic       addr_full, addr_empty;
  logic       meta_full, meta_empty;

  assign addr_wr_hit = bus.wr_en && (bus.wr_addr == axi_addr_t'(MH_ADDR_FIFO_OFFSET));
  assign meta_wr_hit = bus.wr_en && (bus.wr_addr == axi_addr_t'(MH_META_FIFO_OFFSET));

  // Miss has priority, a coinciding AXI push is lost
  assign addr_push = miss_i || addr_wr_hit;
  assign addr_din  = miss_i ? miss_addr_i : bus.wr_data[ADDR_WIDTH_VIRT-1:0];
  assign meta_push = miss_i || meta_wr_hit;
  assign meta_din  = miss_i ? miss_meta_i : bus.wr_data[MISS_META_WIDTH-1:0];

  assign mh_fifo_full_o = (addr_push && addr_full) || (meta_push && meta_full);

  assign addr_rd_hit = (bus.rd_addr == axi_addr_t'(MH_ADDR_FIFO_OFFSET));
  assign meta_rd_hit = (bus.rd_addr == axi_addr_t'(MH_META_FIFO_OFFSET));
  assign bus.mh_hit  = addr_rd_hit || meta_rd_hit;

  assign addr_pop = bus.rd_pop && addr_rd_hit && !addr_empty;
  assign meta_pop = bus.rd_pop && meta_rd_hit && !meta_empty;

  always_comb
  begin
    bus.mh_rdata = '0;
    if (addr_rd_hit)
    begin
      bus.mh_rdata[ADDR_WIDTH_VIRT-1:0] = addr_dout;
    end
    else if (meta_rd_hit)
    begin
      bus.mh_rdata[META_EMPTY_BIT]      = meta_empty; // Lets software poll
      bus.mh_rdata[MISS_META_WIDTH-1:0] = meta_dout;
    end
  end

  mh_fifo #(
    .DATA_WIDTH ( ADDR_WIDTH_VIRT ),
    .DEPTH      ( MH_FIFO_DEPTH   )
  ) u_addr_fifo (
    .Clk_CI  ( Clk_CI                  ),
    .Rst_RBI ( Rst_RBI                 ),
    .push_i  ( addr_push && !addr_full ),
    .data_i  ( addr_din                ),
    .pop_i   ( addr_pop                ),
    .data_o  ( addr_dout               ),
    .empty_o ( addr_empty              ),
    .full_o  ( addr_full               )
  );

  mh_fifo #(
    .DATA_WIDTH ( MISS_META_WIDTH ),
    .DEPTH      ( MH_FIFO_DEPTH   )
  ) u_meta_fifo (
    .Clk_CI  ( Clk_CI                  ),
    .Rst_RBI ( Rst_RBI                 ),
    .push_i  ( meta_push && !meta_full ),
    .data_i  ( meta_din                ),
    .pop_i   ( meta_pop                ),
    .data_o  ( meta_dout               ),
    .empty_o ( meta_empty              ),
    .full_o  ( meta_full               )
  );

endmodule

// File: hw/rab_cfg_pkg.sv
package rab_cfg_pkg;

  // AXI4-Lite side
  localparam int unsigned AXI_DATA_WIDTH = 64;
  localparam int unsigned AXI_ADDR_WIDTH = 32;
  localparam int unsigned AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
  localparam logic [1:0]  AXI_RESP_OKAY  = 2'b00;

  // L1 register bank, 4 slices of 4 registers
  localparam int unsigned N_REGS         = 16;
  localparam int unsigned ADDR_LSB       = 3;   // 64-bit registers
  localparam int unsigned ADDR_MSB       = 6;
  localparam int unsigned CFG_SPACE_SIZE = 128; // Bytes

  // Slice field widths
  localparam int unsigned ADDR_WIDTH_VIRT = 32;
  localparam int unsigned ADDR_WIDTH_PHYS = 40;
  localparam int unsigned N_FLAGS         = 4;

  // Miss handling
  localparam int unsigned MISS_META_WIDTH     = 10;
  localparam int unsigned MH_FIFO_DEPTH       = 8;
  localparam int unsigned MH_ADDR_FIFO_OFFSET = 0;
  localparam int unsigned MH_META_FIFO_OFFSET = 8;
  localparam int unsigned META_EMPTY_BIT      = 31;

  typedef logic [AXI_ADDR_WIDTH-1:0]    axi_addr_t;
  typedef logic [AXI_DATA_WIDTH-1:0]    axi_data_t;
  typedef logic [AXI_STRB_WIDTH-1:0]    axi_strb_t;
  typedef logic [ADDR_WIDTH_VIRT-1:0]   virt_addr_t;
  typedef logic [MISS_META_WIDTH-1:0]   miss_meta_t;
  typedef logic [ADDR_MSB-ADDR_LSB:0]   reg_idx_t;

  // Write side: address and data may arrive in either order
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR, // Address held, waiting for data
    WR_DATA, // Data held, waiting for address
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

endpackage

// File: hw/rab_cfg_top.sv
`timescale 1ns/1ps

module rab_cfg_top (
  input  logic                                             Clk_CI,
  input  logic                                             Rst_RBI,
  input  rab_cfg_pkg::axi_addr_t                           s_axi_awaddr_i,
  input  logic                                             s_axi_awvalid_i,
  output logic                                             s_axi_awready_o,
  input  rab_cfg_pkg::axi_data_t                           s_axi_wdata_i,
  input  rab_cfg_pkg::axi_strb_t                           s_axi_wstrb_i,
  input  logic                                             s_axi_wvalid_i,
  output logic                                             s_axi_wready_o,
  output logic [1:0]                                       s_axi_bresp_o,
  output logic                                             s_axi_bvalid_o,
  input  logic                                             s_axi_bready_i,
  input  rab_cfg_pkg::axi_addr_t                           s_axi_araddr_i,
  input  logic                                             s_axi_arvalid_i,
  output logic                                             s_axi_arready_o,
  output rab_cfg_pkg::axi_data_t                           s_axi_rdata_o,
  output logic [1:0]                                       s_axi_rresp_o,
  output logic                                             s_axi_rvalid_o,
  input  logic                                             s_axi_rready_i,
  output rab_cfg_pkg::axi_data_t [rab_cfg_pkg::N_REGS-1:0] l1_cfg_o,
  input  rab_cfg_pkg::virt_addr_t                          miss_addr_i,
  input  rab_cfg_pkg::miss_meta_t                          miss_meta_i,
  input  logic                                             miss_i,
  output logic                                             mh_fifo_full_o
);

  cfg_bus_if u_bus ();

  axi_lite_cfg_slave u_slave (
    .Clk_CI          ( Clk_CI          ),
    .Rst_RBI         ( Rst_RBI         ),
    .s_axi_awaddr_i  ( s_axi_awaddr_i  ),
    .s_axi_awvalid_i ( s_axi_awvalid_i ),
    .s_axi_awready_o ( s_axi_awready_o ),
    .s_axi_wdata_i   ( s_axi_wdata_i   ),
    .s_axi_wstrb_i   ( s_axi_wstrb_i   ),
    .s_axi_wvalid_i  ( s_axi_wvalid_i  ),
    .s_axi_wready_o  ( s_axi_wready_o  ),
    .s_axi_bresp_o   ( s_axi_bresp_o   ),
    .s_axi_bvalid_o  ( s_axi_bvalid_o  ),
    .s_axi_bready_i  ( s_axi_bready_i  ),
    .s_axi_araddr_i  ( s_axi_araddr_i  ),
    .s_axi_arvalid_i ( s_axi_arvalid_i ),
    .s_axi_arready_o ( s_axi_arready_o ),
    .s_axi_rdata_o   ( s_axi_rdata_o   ),
    .s_axi_rresp_o   ( s_axi_rresp_o   ),
    .s_axi_rvalid_o  ( s_axi_rvalid_o  ),
    .s_axi_rready_i  ( s_axi_rready_i  ),
    .bus             ( u_bus.slave     )
  );

  l1_cfg_regs u_l1_cfg_regs (
    .Clk_CI   ( Clk_CI   ),
    .Rst_RBI  ( Rst_RBI  ),
    .bus      ( u_bus.l1 ),
    .l1_cfg_o ( l1_cfg_o )
  );

  miss_handler u_miss_handler (
    .Clk_CI         ( Clk_CI         ),
    .Rst_RBI        ( Rst_RBI        ),
    .bus            ( u_bus.mh       ),
    .miss_addr_i    ( miss_addr_i    ),
    .miss_meta_i    ( miss_meta_i    ),
    .miss_i         ( miss_i         ),
    .mh_fifo_full_o ( mh_fifo_full_o )
  );

endmodule

// File: test/tb_rab_cfg.sv
`timescale 1ns/1ps

module tb_rab_cfg;
  import rab_cfg_pkg::*;

  localparam int unsigned N_REG_OPS = 60;   // Write and read pairs
  localparam int unsigned N_MIX_OPS = 120;
  localparam int unsigned N_DRAIN   = 2 * (MH_FIFO_DEPTH + 2);
  localparam int unsigned N_OOR_OPS = 20;
  localparam int unsigned N_TRANS   = 2 * N_REG_OPS + N_MIX_OPS + 4 + N_DRAIN + 2 * N_OOR_OPS;
  localparam int unsigned CYC_BOUND = 40;   // Per transaction

  logic                    clk, rst_n;
  axi_addr_t               awaddr, araddr;
  axi_data_t               wdata, rdata;
  axi_strb_t               wstrb;
  logic                    awvalid, wvalid, bready, arvalid, rready;
  logic                    awready, wready, bvalid, arready, rvalid;
  logic [1:0]              bresp, rresp;
  axi_data_t [N_REGS-1:0]  l1_cfg;
  virt_addr_t              miss_addr;
  miss_meta_t              miss_meta;
  logic                    miss, mh_full;

  // Reference model
  axi_data_t   model_regs [N_REGS];
  virt_addr_t  addr_q [$];
  miss_meta_t  meta_q [$];
  axi_addr_t   cur_waddr, rd_addr_cap;
  axi_data_t   cur_wdata, exp_rdata;
  axi_strb_t   cur_wstrb;
  logic        b_seen, pop_ok, exp_full, miss_on;
  logic        aw_held, w_held, b_pend, r_pend;   // Channel state
  int unsigned miss_pct, full_seen;

  rab_cfg_top u_rab_cfg_top (
    .Clk_CI          ( clk       ),
    .Rst_RBI         ( rst_n     ),
    .s_axi_awaddr_i  ( awaddr    ),
    .s_axi_awvalid_i ( awvalid   ),
    .s_axi_awready_o ( awready   ),
    .s_axi_wdata_i   ( wdata     ),
    .s_axi_wstrb_i   ( wstrb     ),
    .s_axi_wvalid_i  ( wvalid    ),
    .s_axi_wready_o  ( wready    ),
    .s_axi_bresp_o   ( bresp     ),
    .s_axi_bvalid_o  ( bvalid    ),
    .s_axi_bready_i  ( bready    ),
    .s_axi_araddr_i  ( araddr    ),
    .s_axi_arvalid_i ( arvalid   ),
    .s_axi_arready_o ( arready   ),
    .s_axi_rdata_o   ( rdata     ),
    .s_axi_rresp_o   ( rresp     ),
    .s_axi_rvalid_o  ( rvalid    ),
    .s_axi_rready_i  ( rready    ),
    .l1_cfg_o        ( l1_cfg    ),
    .miss_addr_i     ( miss_addr ),
    .miss_meta_i     ( miss_meta ),
    .miss_i          ( miss      ),
    .mh_fifo_full_o  ( mh_full   )
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Valid bits per register kind in slice order start end phys flags
  function automatic axi_data_t width_mask(int unsigned idx);
    int unsigned w;
    case (idx % 4)
      0, 1:    w = ADDR_WIDTH_VIRT;
      2:       w = ADDR_WIDTH_PHYS;
      default: w = N_FLAGS;
    endcase
    return (axi_data_t'(1) << w) - 1;
  endfunction

  function automatic axi_data_t predict_read(axi_addr_t addr);
    axi_data_t d;
    axi_data_t r;
    d = '0;
    if (addr == MH_ADDR_FIFO_OFFSET)
    begin
      if (addr_q.size() > 0)
        d[ADDR_WIDTH_VIRT-1:0] = addr_q[0];
    end
    else if (addr == MH_META_FIFO_OFFSET)
    begin
      d[META_EMPTY_BIT] = (meta_q.size() == 0);
      if (meta_q.size() > 0)
        d[MISS_META_WIDTH-1:0] = meta_q[0];
    end
    else
    begin
      r = model_regs[addr[ADDR_MSB:ADDR_LSB]];
      d = addr[2] ? (r >> 32) : r;   // Upper word in the low half
    end
    return d;
  endfunction

  task automatic check_value(string name, axi_data_t exp, axi_data_t got);
    assert (got === exp)
    else
    begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, got);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic push_addr(virt_addr_t a);
    if (addr_q.size() < MH_FIFO_DEPTH)
      addr_q.push_back(a);
    else
      exp_full = 1'b1;
  endtask

  task automatic push_meta(miss_meta_t m);
    if (meta_q.size() < MH_FIFO_DEPTH)
      meta_q.push_back(m);
    else
      exp_full = 1'b1;
  endtask

  // Model follows at the falling edge what the next rising edge commits
  always @(negedge clk)
  begin
    logic        wr_now;
    int unsigned ri;
    if (rst_n)
    begin
      for (int r = 0; r < N_REGS; r++)
        check_value($sformatf("l1_cfg_o[%0d]", r), model_regs[r], l1_cfg[r]);
      check_value("s_axi_awready_o", !aw_held && !b_pend, awready);
      check_value("s_axi_wready_o", !w_held && !b_pend, wready);
      check_value("s_axi_bvalid_o", b_pend, bvalid);
      check_value("s_axi_arready_o", !r_pend, arready);
      check_value("s_axi_rvalid_o", r_pend, rvalid);
      if (arvalid && arready)
      begin
        exp_rdata   = predict_read(araddr);
        rd_addr_cap = araddr;
        pop_ok      = (araddr == MH_ADDR_FIFO_OFFSET) ? (addr_q.size() > 0)
                                                      : (meta_q.size() > 0);
      end
      wr_now   = bvalid && !b_seen;   // First bvalid cycle carries the write
      exp_full = 1'b0;
      if (miss)
      begin
        push_addr(miss_addr);
        push_meta(miss_meta);
      end
      else if (wr_now && cur_waddr == MH_ADDR_FIFO_OFFSET)
        push_addr(cur_wdata[ADDR_WIDTH_VIRT-1:0]);
      else if (wr_now && cur_waddr == MH_META_FIFO_OFFSET)
        push_meta(cur_wdata[MISS_META_WIDTH-1:0]);
      if (wr_now && cur_waddr < CFG_SPACE_SIZE)
      begin
        ri = cur_waddr[ADDR_MSB:ADDR_LSB];
        for (int b = 0; b < AXI_STRB_WIDTH; b++)
          if (cur_wstrb[b])
            model_regs[ri][b*8 +: 8] = cur_wdata[b*8 +: 8];
        model_regs[ri] &= width_mask(ri);
      end
      b_seen = bvalid;
      check_value("mh_fifo_full_o", exp_full, mh_full);
      if (exp_full)
        full_seen++;
      if (rvalid && rready && pop_ok)
      begin
        if (rd_addr_cap == MH_ADDR_FIFO_OFFSET)
          void'(addr_q.pop_front());
        else if (rd_addr_cap == MH_META_FIFO_OFFSET)
          void'(meta_q.pop_front());
      end
      // AW and W in any order, then B until bready
      if (b_pend)
        b_pend = !bready;
      else
      begin
        aw_held = aw_held || awvalid;
        w_held  = w_held || wvalid;
        if (aw_held && w_held)
        begin
          b_pend  = 1'b1;
          aw_held = 1'b0;
          w_held  = 1'b0;
        end
      end
      r_pend = r_pend ? !rready : arvalid;
    end
  end

  // Random miss source
  always @(posedge clk)
  begin
    miss      <= rst_n && miss_on && ($urandom_range(99, 0) < miss_pct);
    miss_addr <= virt_addr_t'($urandom) | virt_addr_t'(1);   // Zero reads as empty
    miss_meta <= miss_meta_t'($urandom);
  end

  task automatic axi_write(axi_addr_t addr, axi_data_t data, axi_strb_t strb);
    logic done;
    cur_waddr = addr;
    cur_wdata = data;
    cur_wstrb = strb;
    fork
      begin
        repeat ($urandom_range(3, 0)) @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        @(negedge clk);
        while (!awready)
          @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
      end
      begin
        repeat ($urandom_range(3, 0)) @(posedge clk);
        wdata  <= data;
        wstrb  <= strb;
        wvalid <= 1'b1;
        @(negedge clk);
        while (!wready)
          @(negedge clk);
        @(posedge clk);
        wvalid <= 1'b0;
      end
    join
    done = 1'b0;
    while (!done)
    begin
      bready <= ($urandom_range(3, 0) != 0);
      @(negedge clk);
      done = bvalid && bready;
      if (done)
        check_value("s_axi_bresp_o", AXI_RESP_OKAY, bresp);
      @(posedge clk);
    end
    bready <= 1'b0;
  endtask

  task automatic axi_read(axi_addr_t addr);
    logic done;
    repeat ($urandom_range(3, 0)) @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready)
      @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    done = 1'b0;
    while (!done)
    begin
      rready <= ($urandom_range(3, 0) != 0);
      @(negedge clk);
      done = rvalid && rready;
      if (done)
      begin
        check_value("s_axi_rdata_o", exp_rdata, rdata);
        check_value("s_axi_rresp_o", AXI_RESP_OKAY, rresp);
      end
      @(posedge clk);
    end
    rready <= 1'b0;
  endtask

  initial
  begin
    #(N_TRANS * CYC_BOUND * 4 + 1000);
    $display("Timeout, the transactions did not complete in time");
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    int unsigned idx;
    void'($urandom(32'h8161));
    rst_n     <= 1'b0;
    awaddr    <= '0;
    awvalid   <= 1'b0;
    wdata     <= '0;
    wstrb     <= '0;
    wvalid    <= 1'b0;
    bready    <= 1'b0;
    araddr    <= '0;
    arvalid   <= 1'b0;
    rready    <= 1'b0;
    miss      <= 1'b0;
    miss_addr <= '0;
    miss_meta <= '0;
    miss_on   <= 1'b0;
    miss_pct  <= 0;
    b_seen     = 1'b0;
    pop_ok     = 1'b0;
    aw_held    = 1'b0;
    w_held     = 1'b0;
    b_pend     = 1'b0;
    r_pend     = 1'b0;
    full_seen  = 0;
    model_regs = '{default: '0};
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Register bank with random strobes and word reads of both halves
    repeat (N_REG_OPS)
    begin
      idx = $urandom_range(N_REGS - 1, 0);
      axi_write(axi_addr_t'(idx << ADDR_LSB), {$urandom, $urandom}, axi_strb_t'($urandom));
      axi_read(axi_addr_t'($urandom_range(2 * N_REGS - 1, 0) << 2));
    end

    // Misses mixed with FIFO reads and FIFO address writes
    miss_pct <= 30;
    miss_on  <= 1'b1;
    repeat (N_MIX_OPS)
    begin
      case ($urandom_range(3, 0))
        0:       axi_read(axi_addr_t'(MH_ADDR_FIFO_OFFSET));
        1:       axi_read(axi_addr_t'(MH_META_FIFO_OFFSET));
        2:       axi_write(axi_addr_t'($urandom_range(1, 0) << ADDR_LSB),
                           {$urandom, $urandom}, '1);
        default: axi_read(axi_addr_t'($urandom_range(2 * N_REGS - 1, 0) << 2));
      endcase
    end

    // Miss in every cycle so writes collide and the FIFOs overflow
    miss_pct <= 100;
    repeat (4)
      axi_write(axi_addr_t'($urandom_range(1, 0) << ADDR_LSB), {$urandom, $urandom}, '1);
    miss_on <= 1'b0;
    repeat (N_DRAIN / 2)
    begin
      axi_read(axi_addr_t'(MH_ADDR_FIFO_OFFSET));
      axi_read(axi_addr_t'(MH_META_FIFO_OFFSET));
    end

    // Outside the register space
    repeat (N_OOR_OPS)
    begin
      axi_write(axi_addr_t'(CFG_SPACE_SIZE + ($urandom_range(255, 0) << ADDR_LSB)),
                {$urandom, $urandom}, axi_strb_t'($urandom));
      axi_read(axi_addr_t'($urandom_range(2 * N_REGS - 1, 0) << 2));
    end

    repeat (2) @(posedge clk);
    if (full_seen == 0)
    begin
      $display("mh_fifo_full_o never rose during the overflow burst");
      $display("SIMULATION FAILED");
      $fatal(1, "overflow not exercised");
    end
    else
    begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// File: verilog.f
hw/rab_cfg_pkg.sv
hw/cfg_bus_if.sv
hw/mh_fifo.sv
hw/miss_handler.sv
hw/l1_cfg_regs.sv
hw/axi_lite_cfg_slave.sv
hw/rab_cfg_top.sv
test/tb_rab_cfg.sv
